/* Bender.yml */
package:
  name: nat_rewrite

sources:
  - rtl/nat_pkg.sv
  - rtl/chksum_incr_update.sv
  - rtl/nat_xlate_table.sv
  - rtl/nat_rewrite_top.sv
  - target: simulation
    files:
      - tb/nat_rewrite_properties.sv
      - tb/tb_nat_rewrite.sv

/* rtl/chksum_incr_update.sv */
////////////////////
// incremental checksum update for one changed 32-bit address
// new_chksum appears two cycles after the inputs are applied
////////////////////
`timescale 1ns/100ps

module chksum_incr_update (
    input  logic                           clk,
    input  logic [nat_pkg::chksum_w-1:0]   old_chksum,
    input  logic [nat_pkg::ip_addr_w-1:0]  old_ip_addr,
    input  logic [nat_pkg::ip_addr_w-1:0]  new_ip_addr,
    output logic [nat_pkg::chksum_w-1:0]   new_chksum
);

    import nat_pkg::*;

    // stage 1, address folding and difference
    logic [chksum_w:0]   old_sum_raw;
    logic [chksum_w-1:0] old_sum;
    logic [chksum_w:0]   new_sum_raw;
    logic [chksum_w-1:0] new_sum;
    logic [chksum_w:0]   diff_raw;
    logic [chksum_w-1:0] diff;

    // stage 2, applying the difference
    logic [chksum_w-1:0] diff_q;
    logic [chksum_w-1:0] old_chksum_q;
    logic [chksum_w:0]   upd_raw;
    logic [chksum_w-1:0] upd_sum;
    logic [chksum_w-1:0] new_chksum_q;

    // fold each address into 16 bits, carry goes back around
    assign old_sum_raw = {1'b0, old_ip_addr[chksum_w-1:0]}
                       + {1'b0, old_ip_addr[ip_addr_w-1:chksum_w]};
    assign old_sum     = old_sum_raw[chksum_w-1:0]
                       + {{(chksum_w-1){1'b0}}, old_sum_raw[chksum_w]};

    assign new_sum_raw = {1'b0, new_ip_addr[chksum_w-1:0]}
                       + {1'b0, new_ip_addr[ip_addr_w-1:chksum_w]};
    assign new_sum     = new_sum_raw[chksum_w-1:0]
                       + {{(chksum_w-1){1'b0}}, new_sum_raw[chksum_w]};

    // difference is ~old + new
    assign diff_raw = {1'b0, ~old_sum} + {1'b0, new_sum};
    assign diff     = diff_raw[chksum_w-1:0]
                    + {{(chksum_w-1){1'b0}}, diff_raw[chksum_w]};

    always_ff @(posedge clk) begin
        diff_q       <= diff;
        old_chksum_q <= old_chksum;
    end

    // new checksum is ~(~old_chksum + diff)
    assign upd_raw = {1'b0, ~old_chksum_q} + {1'b0, diff_q};
    assign upd_sum = upd_raw[chksum_w-1:0]
                   + {{(chksum_w-1){1'b0}}, upd_raw[chksum_w]};

    always_ff @(posedge clk) begin
        new_chksum_q <= ~upd_sum;
    end

    assign new_chksum = new_chksum_q;

endmodule

/* rtl/nat_pkg.sv */
////////////////////
// shared widths and sizes for the source NAT rewrite block
// modules import this in their body, or use scoped names in port lists
////////////////////
package nat_pkg;

    // IPv4 address width
    localparam int ip_addr_w = 32;

    // ip header and tcp checksums are both 16 bit one's-complement sums
    localparam int chksum_w = 16;

    // translation table size
    localparam int nat_entries = 8;
    localparam int nat_idx_w = $clog2(nat_entries);

    // in_valid to out_valid
    // 1 cycle table lookup, then 2 cycles of checksum update
    localparam int nat_latency = 3;

endpackage

/* rtl/nat_rewrite_top.sv */
////////////////////
// source NAT rewrite of outbound IPv4/TCP header fields
// one packet per in_valid strobe, results on out_valid three cycles later
////////////////////
`timescale 1ns/100ps

module nat_rewrite_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cfg_we,
    input  logic [nat_pkg::nat_idx_w-1:0]  cfg_idx,
    input  logic                           cfg_entry_valid,
    input  logic [nat_pkg::ip_addr_w-1:0]  cfg_priv_ip,
    input  logic [nat_pkg::ip_addr_w-1:0]  cfg_pub_ip,
    input  logic                           in_valid,
    input  logic [nat_pkg::ip_addr_w-1:0]  in_src_ip,
    input  logic [nat_pkg::ip_addr_w-1:0]  in_dst_ip,
    input  logic [nat_pkg::chksum_w-1:0]   in_ip_chksum,
    input  logic [nat_pkg::chksum_w-1:0]   in_tcp_chksum,
    output logic                           out_valid,
    output logic                           out_hit,
    output logic [nat_pkg::ip_addr_w-1:0]  out_src_ip,
    output logic [nat_pkg::ip_addr_w-1:0]  out_dst_ip,
    output logic [nat_pkg::chksum_w-1:0]   out_ip_chksum,
    output logic [nat_pkg::chksum_w-1:0]   out_tcp_chksum
);

    import nat_pkg::*;

    // table result, one cycle after in_valid
    logic                 lookup_hit;
    logic [ip_addr_w-1:0] lookup_old_ip;
    logic [ip_addr_w-1:0] lookup_new_ip;

    // updater results, nat_latency cycles after in_valid
    logic [chksum_w-1:0]  ip_chksum_upd;
    logic [chksum_w-1:0]  tcp_chksum_upd;

    // alignment registers
    logic [nat_latency-1:0] valid_pipe;
    logic [ip_addr_w-1:0]   dst_pipe     [nat_latency];
    logic [chksum_w-1:0]    ip_chk_pipe  [nat_latency];
    logic [chksum_w-1:0]    tcp_chk_pipe [nat_latency];
    logic                   hit_pipe     [nat_latency-1];
    logic [ip_addr_w-1:0]   new_ip_pipe  [nat_latency-1];

    nat_xlate_table u_table (
        .clk             (clk),
        .rst             (rst),
        .cfg_we          (cfg_we),
        .cfg_idx         (cfg_idx),
        .cfg_entry_valid (cfg_entry_valid),
        .cfg_priv_ip     (cfg_priv_ip),
        .cfg_pub_ip      (cfg_pub_ip),
        .query_ip        (in_src_ip),
        .lookup_hit      (lookup_hit),
        .lookup_old_ip   (lookup_old_ip),
        .lookup_new_ip   (lookup_new_ip)
    );

    // the pseudo-header carries the source address, so the tcp sum takes
    // the same difference as the ip header sum
    chksum_incr_update u_ip_chksum (
        .clk         (clk),
        .old_chksum  (ip_chk_pipe[0]),
        .old_ip_addr (lookup_old_ip),
        .new_ip_addr (lookup_new_ip),
        .new_chksum  (ip_chksum_upd)
    );

    chksum_incr_update u_tcp_chksum (
        .clk         (clk),
        .old_chksum  (tcp_chk_pipe[0]),
        .old_ip_addr (lookup_old_ip),
        .new_ip_addr (lookup_new_ip),
        .new_chksum  (tcp_chksum_upd)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[nat_latency-2:0], in_valid};
        end
    end

    // stage 0 of the checksum chain lines up with the table result
    always_ff @(posedge clk) begin
        dst_pipe[0]     <= in_dst_ip;
        ip_chk_pipe[0]  <= in_ip_chksum;
        tcp_chk_pipe[0] <= in_tcp_chksum;
        for (int i = 1; i < nat_latency; i++) begin
            dst_pipe[i]     <= dst_pipe[i-1];
            ip_chk_pipe[i]  <= ip_chk_pipe[i-1];
            tcp_chk_pipe[i] <= tcp_chk_pipe[i-1];
        end
    end

    // hit and new address follow the updater through its two stages
    always_ff @(posedge clk) begin
        hit_pipe[0]    <= lookup_hit;
        new_ip_pipe[0] <= lookup_new_ip;
        for (int i = 1; i < nat_latency - 1; i++) begin
            hit_pipe[i]    <= hit_pipe[i-1];
            new_ip_pipe[i] <= new_ip_pipe[i-1];
        end
    end

    assign out_valid  = valid_pipe[nat_latency-1];
    assign out_hit    = hit_pipe[nat_latency-2];
    assign out_src_ip = new_ip_pipe[nat_latency-2];
    assign out_dst_ip = dst_pipe[nat_latency-1];

    // on a miss pass the original sums through untouched
    assign out_ip_chksum  = out_hit ? ip_chksum_upd  : ip_chk_pipe[nat_latency-1];
    assign out_tcp_chksum = out_hit ? tcp_chksum_upd : tcp_chk_pipe[nat_latency-1];

endmodule

/* rtl/nat_xlate_table.sv */
////////////////////
// private to public source address table, written through the cfg port
// lookup result is registered, one cycle after query_ip
////////////////////
`timescale 1ns/100ps

module nat_xlate_table (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cfg_we,
    input  logic [nat_pkg::nat_idx_w-1:0]  cfg_idx,
    input  logic                           cfg_entry_valid,
    input  logic [nat_pkg::ip_addr_w-1:0]  cfg_priv_ip,
    input  logic [nat_pkg::ip_addr_w-1:0]  cfg_pub_ip,
    input  logic [nat_pkg::ip_addr_w-1:0]  query_ip,
    output logic                           lookup_hit,
    output logic [nat_pkg::ip_addr_w-1:0]  lookup_old_ip,
    output logic [nat_pkg::ip_addr_w-1:0]  lookup_new_ip
);

    import nat_pkg::*;

    // entry storage
    logic [nat_entries-1:0] entry_valid;
    logic [ip_addr_w-1:0]   entry_priv [nat_entries];
    logic [ip_addr_w-1:0]   entry_pub  [nat_entries];

    // match and select
    logic [nat_entries-1:0] match;
    logic                   sel_hit;
    logic [nat_idx_w-1:0]   sel_idx;
    logic [ip_addr_w-1:0]   sel_new_ip;

    // registered result
    logic                   hit_q;
    logic [ip_addr_w-1:0]   old_ip_q;
    logic [ip_addr_w-1:0]   new_ip_q;

    // valid bits are the only control state here
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (cfg_we) begin
            entry_valid[cfg_idx] <= cfg_entry_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_we) begin
            entry_priv[cfg_idx] <= cfg_priv_ip;
            entry_pub[cfg_idx]  <= cfg_pub_ip;
        end
    end

    // compare against every entry in parallel
    always_comb begin
        for (int i = 0; i < nat_entries; i++) begin
            match[i] = entry_valid[i] && (entry_priv[i] == query_ip);
        end
    end

    // walk from the top down so the lowest matching index is kept
    always_comb begin
        sel_hit = 1'b0;
        sel_idx = '0;
        for (int i = nat_entries - 1; i >= 0; i--) begin
            if (match[i]) begin
                sel_hit = 1'b1;
                sel_idx = nat_idx_w'(i);
            end
        end
    end

    // a miss keeps the original address
    assign sel_new_ip = sel_hit ? entry_pub[sel_idx] : query_ip;

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= sel_hit;
        end
    end

    always_ff @(posedge clk) begin
        old_ip_q <= query_ip;
        new_ip_q <= sel_new_ip;
    end

    assign lookup_hit    = hit_q;
    assign lookup_old_ip = old_ip_q;
    assign lookup_new_ip = new_ip_q;

endmodule

/* sim.f */
rtl/nat_pkg.sv
rtl/chksum_incr_update.sv
rtl/nat_xlate_table.sv
rtl/nat_rewrite_top.sv
tb/nat_rewrite_properties.sv
tb/tb_nat_rewrite.sv

/* tb/nat_rewrite_properties.sv */
////////////////////
// timing assertions for the NAT rewrite top level, attached with bind
////////////////////
`timescale 1ns/100ps

module nat_rewrite_properties (
    input logic                           clk,
    input logic                           rst,
    input logic                           in_valid,
    input logic                           out_valid,
    input logic                           out_hit,
    input logic [nat_pkg::ip_addr_w-1:0]  in_src_ip,
    input logic [nat_pkg::ip_addr_w-1:0]  out_src_ip
);

    import nat_pkg::*;

    // nothing comes out during reset or in the cycle after it
    a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high during or right after reset");

    a_valid_latency: assert property (@(posedge clk) disable iff (rst)
        out_valid == $past(in_valid, nat_latency))
        else $error("out_valid does not follow in_valid by %0d cycles", nat_latency);

    // a miss keeps the source address
    a_miss_src: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_hit) |-> out_src_ip == $past(in_src_ip, nat_latency))
        else $error("source address changed on a table miss");

endmodule

bind nat_rewrite_top nat_rewrite_properties u_properties (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .out_hit    (out_hit),
    .in_src_ip  (in_src_ip),
    .out_src_ip (out_src_ip)
);

/* tb/tb_nat_rewrite.sv */
////////////////////
// testbench for the NAT rewrite top level
// programs the table, sends directed and random packets, checks every output
////////////////////
`timescale 1ns/100ps

module tb_nat_rewrite;

    import nat_pkg::*;

    localparam int exp_w = 1 + 2 * ip_addr_w + 2 * chksum_w;

    logic                 clk;
    logic                 rst;
    logic                 cfg_we;
    logic [nat_idx_w-1:0] cfg_idx;
    logic                 cfg_entry_valid;
    logic [ip_addr_w-1:0] cfg_priv_ip;
    logic [ip_addr_w-1:0] cfg_pub_ip;
    logic                 in_valid;
    logic [ip_addr_w-1:0] in_src_ip;
    logic [ip_addr_w-1:0] in_dst_ip;
    logic [chksum_w-1:0]  in_ip_chksum;
    logic [chksum_w-1:0]  in_tcp_chksum;
    logic                 out_valid;
    logic                 out_hit;
    logic [ip_addr_w-1:0] out_src_ip;
    logic [ip_addr_w-1:0] out_dst_ip;
    logic [chksum_w-1:0]  out_ip_chksum;
    logic [chksum_w-1:0]  out_tcp_chksum;

    // model copy of the translation table
    logic                 ref_valid [nat_entries];
    logic [ip_addr_w-1:0] ref_priv  [nat_entries];
    logic [ip_addr_w-1:0] ref_pub   [nat_entries];

    // expected outputs and the monitor cycle of each in_valid
    logic [exp_w-1:0] exp_q    [$];
    int               in_cyc_q [$];
    int               cyc;
    int               seed;
    int               n_checked;

    nat_rewrite_top i_nat_rewrite_top (
        .clk             (clk),
        .rst             (rst),
        .cfg_we          (cfg_we),
        .cfg_idx         (cfg_idx),
        .cfg_entry_valid (cfg_entry_valid),
        .cfg_priv_ip     (cfg_priv_ip),
        .cfg_pub_ip      (cfg_pub_ip),
        .in_valid        (in_valid),
        .in_src_ip       (in_src_ip),
        .in_dst_ip       (in_dst_ip),
        .in_ip_chksum    (in_ip_chksum),
        .in_tcp_chksum   (in_tcp_chksum),
        .out_valid       (out_valid),
        .out_hit         (out_hit),
        .out_src_ip      (out_src_ip),
        .out_dst_ip      (out_dst_ip),
        .out_ip_chksum   (out_ip_chksum),
        .out_tcp_chksum  (out_tcp_chksum)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one's-complement add with end-around carry
    function automatic logic [chksum_w-1:0] oc_add(input logic [chksum_w-1:0] a,
                                                   input logic [chksum_w-1:0] b);
        logic [chksum_w:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[chksum_w-1:0] + s[chksum_w];
    endfunction

    // expected {hit, src, dst, ip checksum, tcp checksum} for one packet
    function automatic logic [exp_w-1:0] expected_fields(input logic [ip_addr_w-1:0] src,
                                                         input logic [ip_addr_w-1:0] dst,
                                                         input logic [chksum_w-1:0]  ip_chk,
                                                         input logic [chksum_w-1:0]  tcp_chk);
        logic                 hit;
        logic [ip_addr_w-1:0] new_src;
        logic [chksum_w-1:0]  diff;
        logic [chksum_w-1:0]  ip_res;
        logic [chksum_w-1:0]  tcp_res;
        hit     = 1'b0;
        new_src = src;
        ip_res  = ip_chk;
        tcp_res = tcp_chk;
        // first valid match in index order wins
        for (int i = 0; i < nat_entries; i++) begin
            if (!hit && ref_valid[i] && ref_priv[i] == src) begin
                hit     = 1'b1;
                new_src = ref_pub[i];
            end
        end
        if (hit) begin
            diff    = oc_add(~oc_add(src[31:16], src[15:0]),
                             oc_add(new_src[31:16], new_src[15:0]));
            ip_res  = ~oc_add(~ip_chk, diff);
            tcp_res = ~oc_add(~tcp_chk, diff);
        end
        return {hit, new_src, dst, ip_res, tcp_res};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, want);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic write_entry(input int idx, input logic valid,
                               input logic [ip_addr_w-1:0] priv,
                               input logic [ip_addr_w-1:0] pub);
        @(posedge clk);
        in_valid        <= 1'b0;
        cfg_we          <= 1'b1;
        cfg_idx         <= idx[nat_idx_w-1:0];
        cfg_entry_valid <= valid;
        cfg_priv_ip     <= priv;
        cfg_pub_ip      <= pub;
        ref_valid[idx] = valid;
        ref_priv[idx]  = priv;
        ref_pub[idx]   = pub;
    endtask

    task automatic send_packet(input logic [ip_addr_w-1:0] src,
                               input logic [ip_addr_w-1:0] dst,
                               input logic [chksum_w-1:0]  ip_chk,
                               input logic [chksum_w-1:0]  tcp_chk);
        @(posedge clk);
        cfg_we        <= 1'b0;
        in_valid      <= 1'b1;
        in_src_ip     <= src;
        in_dst_ip     <= dst;
        in_ip_chksum  <= ip_chk;
        in_tcp_chksum <= tcp_chk;
        exp_q.push_back(expected_fields(src, dst, ip_chk, tcp_chk));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
            cfg_we   <= 1'b0;
        end
    endtask

    // compare process samples on the falling edge where outputs are settled
    initial begin
        logic                 w_hit;
        logic [ip_addr_w-1:0] w_src;
        logic [ip_addr_w-1:0] w_dst;
        logic [chksum_w-1:0]  w_ip;
        logic [chksum_w-1:0]  w_tcp;
        cyc = 0;
        forever begin
            @(negedge clk);
            cyc++;
            if (in_valid === 1'b1) in_cyc_q.push_back(cyc);
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0 || in_cyc_q.size() == 0) begin
                    $display("out_valid high at %0t with no packet outstanding", $time);
                    $display("Verification failed");
                    $fatal(1, "unexpected output");
                end else begin
                    {w_hit, w_src, w_dst, w_ip, w_tcp} = exp_q.pop_front();
                    check_value("out_valid latency", cyc - in_cyc_q.pop_front(), nat_latency);
                    check_value("out_hit", out_hit, w_hit);
                    check_value("out_src_ip", out_src_ip, w_src);
                    check_value("out_dst_ip", out_dst_ip, w_dst);
                    check_value("out_ip_chksum", out_ip_chksum, w_ip);
                    check_value("out_tcp_chksum", out_tcp_chksum, w_tcp);
                    n_checked++;
                end
            end
        end
    end

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] src;
        int          wait_cnt;
        seed = 70307;
        n_checked = 0;
        rst = 1'b1;
        cfg_we = 1'b0;
        cfg_idx = '0;
        cfg_entry_valid = 1'b0;
        cfg_priv_ip = '0;
        cfg_pub_ip = '0;
        in_valid = 1'b0;
        in_src_ip = '0;
        in_dst_ip = '0;
        in_ip_chksum = '0;
        in_tcp_chksum = '0;
        for (int i = 0; i < nat_entries; i++) begin
            ref_valid[i] = 1'b0;
            ref_priv[i]  = 32'h0a00_00f0 + i;
            ref_pub[i]   = 32'hcb00_7100 + i;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        idle(2);

        // empty table so even corner checksums pass through as they are
        send_packet(32'h0a00_0001, 32'h0808_0808, 16'hffff, 16'h0000);
        send_packet(32'h0a00_0002, 32'h0101_0101, 16'h0000, 16'hffff);
        send_packet(32'hc0a8_0105, 32'h5db8_d822, 16'h1c46, 16'hb1e6);
        idle(4);

        // four translations and then a hit on each
        for (int i = 0; i < 4; i++) begin
            write_entry(i, 1'b1, 32'h0a00_0001 + i, 32'hcb00_7101 + 32'h0101 * i);
        end
        for (int i = 0; i < 4; i++) begin
            r1 = $random(seed);
            send_packet(ref_priv[i], 32'h0808_0404, r1[15:0], r1[31:16]);
        end
        send_packet(ref_priv[1], 32'h0808_0404, 16'hffff, 16'h0000);
        idle(3);

        // back to back hits mixed with misses
        for (int k = 0; k < 12; k++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            src = (k % 3 == 0) ? r1 : ref_priv[k % 4];
            send_packet(src, r2, r1[15:0], r2[31:16]);
        end
        idle(4);

        // duplicate private address and then invalidate and overwrite
        write_entry(5, 1'b1, ref_priv[2], 32'hc633_6405);
        send_packet(ref_priv[2], 32'h0808_0808, 16'h4321, 16'h8765);
        write_entry(2, 1'b0, ref_priv[2], ref_pub[2]);
        send_packet(ref_priv[2], 32'h0808_0808, 16'h4321, 16'h8765);
        write_entry(5, 1'b1, ref_priv[5], 32'hc633_64aa);
        send_packet(ref_priv[2], 32'h0808_0808, 16'h4321, 16'h8765);
        write_entry(5, 1'b0, ref_priv[5], ref_pub[5]);
        send_packet(ref_priv[2], 32'h0808_0808, 16'h4321, 16'h8765);
        idle(4);

        // random traffic with about half the sources taken from the table
        for (int n = 0; n < 400; n++) begin
            if (n % 100 == 50) begin
                r1 = $random(seed);
                r2 = $random(seed);
                write_entry(r1[2:0], r1[3], 32'h0a00_0100 + r1[7:4], r2);
            end
            r1 = $random(seed);
            r2 = $random(seed);
            r3 = $random(seed);
            src = r3[0] ? ref_priv[r3[3:1]] : r1;
            send_packet(src, r2, r3[31:16], r1[15:0] ^ r2[15:0]);
            idle(r3[5:4]);
        end
        idle(1);

        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < 100) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_q.size() == 0) begin
            $display("checked %0d packets", n_checked);
            $display("Verification passed");
            $finish;
        end else begin
            $display("timeout, %0d packets never came out on out_valid", exp_q.size());
            $display("Verification failed");
            $fatal(1, "output timeout");
        end
    end

endmodule
